//--- rtl/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// bus commands seen by memory
	typedef enum logic [1:0]
	{
		BUS_NONE = 2'h0,
		BUS_LOAD = 2'h1
	} bus_command_t;

	// address and block geometry
	localparam int ADDR_WIDTH          = 64;
	localparam int ICACHE_BLOCK_SIZE   = 64;
	localparam int ICACHE_BLOCK_OFFSET = 3;
	localparam int ICACHE_INDEX_SIZE   = 5;
	localparam int ICACHE_TAG_SIZE     = 56;
	localparam int ICACHE_LINES        = 32;
	localparam int BLOCK_NUM_WIDTH     = ADDR_WIDTH - ICACHE_BLOCK_OFFSET;

	// transaction number zero means no transaction
	localparam int MEM_TAG_WIDTH = 4;

	// outstanding misses
	localparam int MSHR_ENTRIES   = 4;
	localparam int MSHR_PTR_WIDTH = $clog2(MSHR_ENTRIES);

	// prefetch run length after a demand miss
	localparam int PREFETCH_DEPTH     = 2;
	localparam int PREFETCH_CNT_WIDTH = $clog2(PREFETCH_DEPTH + 1);

	typedef struct packed
	{
		logic [ICACHE_TAG_SIZE-1:0]     tag;
		logic [ICACHE_INDEX_SIZE-1:0]   index;
		logic [ICACHE_BLOCK_OFFSET-1:0] offset;
	} icache_addr_fields_t;

	// one fetch address, seen as a raw word or as cache fields
	typedef union packed
	{
		logic [ADDR_WIDTH-1:0] word;
		icache_addr_fields_t   f;
	} icache_addr_t;

endpackage

`default_nettype wire

//--- rtl/icache_lookup_if.sv
`timescale 1ns/10ps
`default_nettype none

interface icache_lookup_if;
	import icache_pkg::*;

	// demand lookup from the processor
	logic [ICACHE_INDEX_SIZE-1:0] dem_index;
	logic [ICACHE_TAG_SIZE-1:0]   dem_tag;
	logic                         dem_read_en;

	// prefetch lookup
	logic [ICACHE_INDEX_SIZE-1:0] pref_index;
	logic [ICACHE_TAG_SIZE-1:0]   pref_tag;
	logic                         pref_read_en;

	// accepted transaction for the request just issued, and returning block
	logic [MEM_TAG_WIDTH-1:0]     mem_response;
	logic [MEM_TAG_WIDTH-1:0]     mem_tag;
	logic [ICACHE_BLOCK_SIZE-1:0] fill_data;

	// storage answers
	logic [ICACHE_BLOCK_SIZE-1:0] hit_data;
	logic                         hit_valid;
	logic                         dem_miss;
	logic                         pref_miss;
	logic                         full;

	modport ctrl (
		output dem_index, dem_tag, dem_read_en,
		output pref_index, pref_tag, pref_read_en,
		output mem_response, mem_tag, fill_data,
		input  hit_data, hit_valid, dem_miss, pref_miss, full
	);

	modport mem (
		input  dem_index, dem_tag, dem_read_en,
		input  pref_index, pref_tag, pref_read_en,
		input  mem_response, mem_tag, fill_data,
		output hit_data, hit_valid, dem_miss, pref_miss, full
	);

endinterface

`default_nettype wire

//--- rtl/icache_cachemem.sv
`timescale 1ns/10ps
`default_nettype none

module icache_cachemem (
	input  logic         clock,
	input  logic         arst_n,
	icache_lookup_if.mem lookup
);
	import icache_pkg::*;

	// line storage
	logic [ICACHE_LINES-1:0]      line_valid;
	logic [ICACHE_TAG_SIZE-1:0]   line_tag  [ICACHE_LINES];
	logic [ICACHE_BLOCK_SIZE-1:0] line_data [ICACHE_LINES];

	// outstanding-miss table
	logic [MSHR_ENTRIES-1:0]      mshr_valid;
	logic [MEM_TAG_WIDTH-1:0]     mshr_txn   [MSHR_ENTRIES];
	logic [ICACHE_INDEX_SIZE-1:0] mshr_index [MSHR_ENTRIES];
	logic [ICACHE_TAG_SIZE-1:0]   mshr_tag   [MSHR_ENTRIES];

	logic                         dem_hit;
	logic                         pref_hit;
	logic                         dem_pending;
	logic                         pref_pending;

	logic                         alloc_en;
	logic [MSHR_PTR_WIDTH-1:0]    alloc_ptr;
	logic [ICACHE_INDEX_SIZE-1:0] alloc_index;
	logic [ICACHE_TAG_SIZE-1:0]   alloc_tag;

	logic                         fill_en;
	logic [MSHR_PTR_WIDTH-1:0]    fill_ptr;

	// combinational lookups
	assign dem_hit = lookup.dem_read_en && line_valid[lookup.dem_index] &&
		(line_tag[lookup.dem_index] == lookup.dem_tag);
	assign pref_hit = lookup.pref_read_en && line_valid[lookup.pref_index] &&
		(line_tag[lookup.pref_index] == lookup.pref_tag);

	// is the block already on its way from memory
	always_comb
	begin
		dem_pending  = 1'b0;
		pref_pending = 1'b0;
		for (int i = 0; i < MSHR_ENTRIES; i++)
		begin
			if (mshr_valid[i] && (mshr_index[i] == lookup.dem_index) &&
				(mshr_tag[i] == lookup.dem_tag))
			begin
				dem_pending = 1'b1;
			end
			if (mshr_valid[i] && (mshr_index[i] == lookup.pref_index) &&
				(mshr_tag[i] == lookup.pref_tag))
			begin
				pref_pending = 1'b1;
			end
		end
	end

	assign lookup.hit_valid = dem_hit;
	assign lookup.hit_data  = line_data[lookup.dem_index];
	assign lookup.dem_miss  = lookup.dem_read_en && !dem_hit && !dem_pending;
	assign lookup.pref_miss = lookup.pref_read_en && !pref_hit && !pref_pending;
	assign lookup.full      = &mshr_valid;

	// lowest free entry, and the entry whose transaction is returning
	always_comb
	begin
		alloc_ptr = '0;
		fill_en   = 1'b0;
		fill_ptr  = '0;
		for (int i = MSHR_ENTRIES - 1; i >= 0; i--)
		begin
			if (!mshr_valid[i])
			begin
				alloc_ptr = MSHR_PTR_WIDTH'(i);
			end
		end
		for (int i = 0; i < MSHR_ENTRIES; i++)
		begin
			if (mshr_valid[i] && (lookup.mem_tag != '0) && (mshr_txn[i] == lookup.mem_tag))
			begin
				fill_en  = 1'b1;
				fill_ptr = MSHR_PTR_WIDTH'(i);
			end
		end
	end

	// demand wins over prefetch, the same choice the controller makes
	assign alloc_index = lookup.dem_miss ? lookup.dem_index : lookup.pref_index;
	assign alloc_tag   = lookup.dem_miss ? lookup.dem_tag : lookup.pref_tag;
	assign alloc_en    = (lookup.mem_response != '0) && !lookup.full &&
		(lookup.dem_miss || lookup.pref_miss);

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			line_valid <= '0;
			mshr_valid <= '0;
		end
		else
		begin
			// fill the line and free its entry on the same edge
			if (fill_en)
			begin
				line_valid[mshr_index[fill_ptr]] <= 1'b1;
				mshr_valid[fill_ptr]             <= 1'b0;
			end
			if (alloc_en)
			begin
				mshr_valid[alloc_ptr] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (fill_en)
		begin
			line_tag[mshr_index[fill_ptr]]  <= mshr_tag[fill_ptr];
			line_data[mshr_index[fill_ptr]] <= lookup.fill_data;
		end
		if (alloc_en)
		begin
			mshr_txn[alloc_ptr]   <= lookup.mem_response;
			mshr_index[alloc_ptr] <= alloc_index;
			mshr_tag[alloc_ptr]   <= alloc_tag;
		end
	end

endmodule

`default_nettype wire

//--- rtl/icache_prefetch.sv
`timescale 1ns/10ps
`default_nettype none

module icache_prefetch (
	input  logic                     clock,
	input  logic                     arst_n,

	// from the controller
	input  logic                     miss_issued,
	input  icache_pkg::icache_addr_t miss_addr,
	input  logic                     pref_issued,

	// prefetch request
	output icache_pkg::icache_addr_t pref_addr,
	output icache_pkg::bus_command_t pref_command
);
	import icache_pkg::*;

	icache_addr_t                  cur_block;
	logic [PREFETCH_CNT_WIDTH-1:0] budget;

	// block after the given one, offset cleared
	function automatic icache_addr_t next_block(input icache_addr_t addr);
		icache_addr_t nxt;
		{nxt.f.tag, nxt.f.index} = {addr.f.tag, addr.f.index} + 1'b1;
		nxt.f.offset = '0;
		return nxt;
	endfunction

	// budget left in the current run
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			budget <= '0;
		end
		else if (miss_issued)
		begin
			budget <= PREFETCH_CNT_WIDTH'(PREFETCH_DEPTH);
		end
		else if (pref_issued && (budget != '0))
		begin
			budget <= budget - 1'b1;
		end
	end

	// a new demand miss restarts the run just past the missed block
	always_ff @(posedge clock)
	begin
		if (miss_issued)
		begin
			cur_block <= next_block(miss_addr);
		end
		else if (pref_issued)
		begin
			cur_block <= next_block(cur_block);
		end
	end

	assign pref_addr    = cur_block;
	assign pref_command = (budget != '0) ? BUS_LOAD : BUS_NONE;

endmodule

`default_nettype wire

//--- rtl/icache_controller.sv
`timescale 1ns/10ps
`default_nettype none

module icache_controller (
	icache_lookup_if.ctrl                          lookup,

	// processor and prefetcher requests
	input  icache_pkg::icache_addr_t               proc_addr,
	input  icache_pkg::bus_command_t               proc_command,
	input  icache_pkg::icache_addr_t               pref_addr,
	input  icache_pkg::bus_command_t               pref_command,

	// memory side
	input  logic [icache_pkg::MEM_TAG_WIDTH-1:0]     mem_response,
	input  logic [icache_pkg::MEM_TAG_WIDTH-1:0]     mem_tag,
	input  logic [icache_pkg::ICACHE_BLOCK_SIZE-1:0] mem_data,
	output icache_pkg::bus_command_t               mem_command,
	output logic [icache_pkg::ADDR_WIDTH-1:0]        mem_addr,

	// back to the processor
	output logic [icache_pkg::ICACHE_BLOCK_SIZE-1:0] icache_data,
	output logic                                   icache_data_valid,

	// to the prefetcher
	output logic                                   miss_issued,
	output icache_pkg::icache_addr_t               miss_addr,
	output logic                                   pref_issued
);
	import icache_pkg::*;

	logic [ADDR_WIDTH-1:0] dem_block;
	logic [ADDR_WIDTH-1:0] pref_block;

	// tag and index straight off the raw address
	assign {lookup.dem_tag, lookup.dem_index} =
		proc_addr.word[ADDR_WIDTH-1:ICACHE_BLOCK_OFFSET];
	assign {lookup.pref_tag, lookup.pref_index} =
		pref_addr.word[ADDR_WIDTH-1:ICACHE_BLOCK_OFFSET];
	assign lookup.dem_read_en  = (proc_command == BUS_LOAD);
	assign lookup.pref_read_en = (pref_command == BUS_LOAD);

	// returning blocks go straight to storage
	assign lookup.mem_tag   = mem_tag;
	assign lookup.fill_data = mem_data;

	// block-aligned bus addresses
	assign dem_block  = {proc_addr.word[ADDR_WIDTH-1:ICACHE_BLOCK_OFFSET],
		{ICACHE_BLOCK_OFFSET{1'b0}}};
	assign pref_block = {pref_addr.word[ADDR_WIDTH-1:ICACHE_BLOCK_OFFSET],
		{ICACHE_BLOCK_OFFSET{1'b0}}};
	assign miss_addr  = icache_addr_t'(dem_block);

	always_comb
	begin
		mem_command         = BUS_NONE;
		mem_addr            = '0;
		lookup.mem_response = '0;
		miss_issued         = 1'b0;
		// a prefetch block that is present or pending needs no load, so move on
		pref_issued         = lookup.pref_read_en && !lookup.pref_miss;
		if (!lookup.full)
		begin
			if (lookup.dem_miss)
			begin
				mem_command         = BUS_LOAD;
				mem_addr            = dem_block;
				lookup.mem_response = mem_response;
				miss_issued         = (mem_response != '0);
			end
			else if (lookup.pref_miss)
			begin
				mem_command         = BUS_LOAD;
				mem_addr            = pref_block;
				lookup.mem_response = mem_response;
				pref_issued         = (mem_response != '0);
			end
		end
	end

	// hit data out, zero otherwise
	assign icache_data_valid = lookup.hit_valid;
	assign icache_data       = lookup.hit_valid ? lookup.hit_data : '0;

endmodule

`default_nettype wire

//--- rtl/icache_top.sv
`timescale 1ns/10ps
`default_nettype none

module icache_top (
	input  logic                                   clock,
	input  logic                                   arst_n,

	// processor side
	input  logic [icache_pkg::ADDR_WIDTH-1:0]        proc_addr,
	input  icache_pkg::bus_command_t               proc_command,
	output logic [icache_pkg::ICACHE_BLOCK_SIZE-1:0] icache_data,
	output logic                                   icache_data_valid,

	// memory side
	output icache_pkg::bus_command_t               mem_command,
	output logic [icache_pkg::ADDR_WIDTH-1:0]        mem_addr,
	input  logic [icache_pkg::MEM_TAG_WIDTH-1:0]     mem_response,
	input  logic [icache_pkg::MEM_TAG_WIDTH-1:0]     mem_tag,
	input  logic [icache_pkg::ICACHE_BLOCK_SIZE-1:0] mem_data
);
	import icache_pkg::*;

	// prefetcher handshake
	icache_addr_t pref_addr;
	bus_command_t pref_command;
	logic         miss_issued;
	icache_addr_t miss_addr;
	logic         pref_issued;

	icache_lookup_if lookup ();

	icache_controller u_controller (
		.lookup            (lookup.ctrl),
		.proc_addr         (proc_addr),
		.proc_command      (proc_command),
		.pref_addr         (pref_addr),
		.pref_command      (pref_command),
		.mem_response      (mem_response),
		.mem_tag           (mem_tag),
		.mem_data          (mem_data),
		.mem_command       (mem_command),
		.mem_addr          (mem_addr),
		.icache_data       (icache_data),
		.icache_data_valid (icache_data_valid),
		.miss_issued       (miss_issued),
		.miss_addr         (miss_addr),
		.pref_issued       (pref_issued)
	);

	icache_cachemem u_cachemem (
		.clock  (clock),
		.arst_n (arst_n),
		.lookup (lookup.mem)
	);

	icache_prefetch u_prefetch (
		.clock        (clock),
		.arst_n       (arst_n),
		.miss_issued  (miss_issued),
		.miss_addr    (miss_addr),
		.pref_issued  (pref_issued),
		.pref_addr    (pref_addr),
		.pref_command (pref_command)
	);

endmodule

`default_nettype wire

//--- bench/icache_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

module icache_top_tb;
	import icache_pkg::*;

	localparam int IMAGE_BLOCKS = 32;
	localparam int MAX_FETCHES  = 16;
	localparam int DATA_WORDS   = IMAGE_BLOCKS + 1 + 2 * MAX_FETCHES;

	logic                         clock;
	logic                         arst_n;
	logic [ADDR_WIDTH-1:0]        proc_addr;
	bus_command_t                 proc_command;
	logic [ICACHE_BLOCK_SIZE-1:0] icache_data;
	logic                         icache_data_valid;
	bus_command_t                 mem_command;
	logic [ADDR_WIDTH-1:0]        mem_addr;
	logic [MEM_TAG_WIDTH-1:0]     mem_response;
	logic [MEM_TAG_WIDTH-1:0]     mem_tag;
	logic [ICACHE_BLOCK_SIZE-1:0] mem_data;

	// image, fetch count, then pairs of fetch entry and expected word
	logic [63:0] tdata [DATA_WORDS];

	// memory model state, indexed by transaction number
	logic [15:0] slot_valid;
	logic [63:0] slot_addr [16];
	int          slot_due  [16];
	logic [3:0]  next_txn;
	logic        refuse_now;
	logic [31:0] rng;

	int cycle;
	int outstanding;
	int accepted_total;
	int errors;
	int tests;
	int failed;
	int fetch_count;
	bit loaded;

	icache_top u_icache_top (
		.clock             (clock),
		.arst_n            (arst_n),
		.proc_addr         (proc_addr),
		.proc_command      (proc_command),
		.icache_data       (icache_data),
		.icache_data_valid (icache_data_valid),
		.mem_command       (mem_command),
		.mem_addr          (mem_addr),
		.mem_response      (mem_response),
		.mem_tag           (mem_tag),
		.mem_data          (mem_data)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// memory answers a load in the same cycle
	assign mem_response = (mem_command == BUS_LOAD && !refuse_now && !slot_valid[next_txn]) ?
		next_txn : 4'd0;

	always @(posedge clock)
	begin : memory_model
		logic [31:0] draw;
		int          ret;
		cycle++;
		draw = lcg_next(rng);
		rng  = draw;
		ret  = 0;
		if (arst_n && mem_command == BUS_LOAD && mem_response != 4'd0)
		begin
			for (int i = 1; i < 16; i++)
			begin
				assert (!(slot_valid[i] && slot_addr[i] == mem_addr))
				else
				begin
					$display("block %h accepted again while still outstanding", mem_addr);
					errors++;
				end
			end
			slot_valid[mem_response] <= 1'b1;
			slot_addr[mem_response]  <= mem_addr;
			slot_due[mem_response]   <= cycle + 3 + int'(draw[20:18]);
			next_txn                 <= (next_txn == 4'd15) ? 4'd1 : next_txn + 4'd1;
			outstanding++;
			accepted_total++;
		end
		for (int i = 15; i >= 1; i--)
		begin
			if (slot_valid[i] && slot_due[i] <= cycle)
				ret = i;
		end
		// one block back per cycle
		if (ret != 0)
		begin
			mem_tag         <= 4'(ret);
			mem_data        <= tdata[slot_addr[ret][7:3]];
			slot_valid[ret] <= 1'b0;
			outstanding--;
		end
		else
		begin
			mem_tag  <= 4'd0;
			mem_data <= '0;
		end
		refuse_now <= (draw[31:30] == 2'b00);
		assert (outstanding <= MSHR_ENTRIES)
		else
		begin
			$display("%0d loads outstanding, more than the miss table holds", outstanding);
			errors++;
		end
	end

	task automatic check_idle(input string when_s);
		assert (mem_command == BUS_NONE && !icache_data_valid)
		else
		begin
			$display("bus command or data valid active %s", when_s);
			errors++;
		end
	endtask

	// one line per finished test
	task automatic report_test(input string name, input int start_errors);
		tests++;
		if (errors == start_errors)
		begin
			$display("%s: ok", name);
		end
		else
		begin
			$display("%s: failed", name);
			failed++;
		end
	endtask

	// no loads in flight and the prefetcher has gone quiet
	task automatic wait_quiet();
		int quiet;
		quiet = 0;
		while (quiet < 3)
		begin
			@(negedge clock);
			if (outstanding == 0 && mem_command == BUS_NONE)
				quiet++;
			else
				quiet = 0;
		end
	endtask

	task automatic run_fetch(input int n);
		logic [63:0] entry;
		logic [63:0] expected;
		logic [7:0]  kind;
		int          start_errors;
		int          start_accepted;
		int          waited;
		string       name;
		entry        = tdata[IMAGE_BLOCKS + 1 + 2 * n];
		expected     = tdata[IMAGE_BLOCKS + 2 + 2 * n];
		kind         = entry[63:56];
		name         = $sformatf("fetch%0d_block%02h", n, entry[7:0]);
		start_errors = errors;
		// kind 0 is a cold miss, 1 a hit, 2 a prefetched block
		if (kind != 8'd0)
			wait_quiet();
		start_accepted = accepted_total;
		@(posedge clock);
		proc_addr    <= 64'(entry[7:0]) << 3;
		proc_command <= BUS_LOAD;
		waited = 0;
		@(negedge clock);
		while (!icache_data_valid)
		begin
			waited++;
			@(negedge clock);
		end
		if (kind == 8'd1)
		begin
			assert (waited == 0)
			else
			begin
				$display("%s: hit was not valid in the cycle it was applied", name);
				errors++;
			end
		end
		assert (icache_data == expected)
		else
		begin
			$display("mismatch %s: expected %h, actual %h", name, expected, icache_data);
			errors++;
		end
		@(posedge clock);
		proc_command <= BUS_NONE;
		// any load driven while the fetch was held has met memory by now
		@(negedge clock);
		if (kind != 8'd0)
		begin
			assert (accepted_total == start_accepted)
			else
			begin
				$display("%s: memory accepted a load for a block already in the cache", name);
				errors++;
			end
		end
		report_test(name, start_errors);
	endtask

	initial
	begin
		int reset_start;
		arst_n       = 1'b0;
		proc_addr    = '0;
		proc_command = BUS_NONE;
		mem_tag      = '0;
		mem_data     = '0;
		slot_valid   = '0;
		next_txn     = 4'd1;
		refuse_now   = 1'b0;
		rng          = 32'h460dc479;
		$readmemh("bench/icache_testdata.hex", tdata);
		fetch_count = int'(tdata[IMAGE_BLOCKS]);
		if (fetch_count > MAX_FETCHES)
			fetch_count = MAX_FETCHES;
		loaded = 1'b1;
		reset_start = errors;
		repeat (4)
		begin
			@(negedge clock);
			check_idle("during reset");
		end
		@(posedge clock);
		arst_n <= 1'b1;
		@(negedge clock);
		check_idle("right after reset");
		report_test("reset", reset_start);
		for (int n = 0; n < fetch_count; n++)
			run_fetch(n);
		wait_quiet();
		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// watchdog
	initial
	begin
		wait (loaded);
		repeat (fetch_count * 40 + 200) @(posedge clock);
		$display("timeout: fetches did not finish in time");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/icache_testdata.hex
// entries 0..31: memory image, block n at byte address n*8
// entry 32: fetch count; then pairs of {kind, block} and expected word (kind 0 miss, 1 hit, 2 prefetched)
0b10c00000000000 0b10c00000000001 0b10c00000000002 0b10c00000000003 0b10c00000000004 0b10c00000000005 0b10c00000000006 0b10c00000000007
0b10c00000000008 0b10c00000000009 0b10c0000000000a 0b10c0000000000b 0b10c0000000000c 0b10c0000000000d 0b10c0000000000e 0b10c0000000000f
0b10c00000000010 0b10c00000000011 0b10c00000000012 0b10c00000000013 0b10c00000000014 0b10c00000000015 0b10c00000000016 0b10c00000000017
0b10c00000000018 0b10c00000000019 0b10c0000000001a 0b10c0000000001b 0b10c0000000001c 0b10c0000000001d 0b10c0000000001e 0b10c0000000001f
0000000000000010
0000000000000000 0b10c00000000000
0200000000000001 0b10c00000000001
0200000000000002 0b10c00000000002
0000000000000005 0b10c00000000005
0200000000000006 0b10c00000000006
0200000000000007 0b10c00000000007
000000000000000c 0b10c0000000000c
020000000000000d 0b10c0000000000d
0000000000000014 0b10c00000000014
000000000000001b 0b10c0000000001b
0000000000000003 0b10c00000000003
0000000000000009 0b10c00000000009
0100000000000000 0b10c00000000000
0100000000000005 0b10c00000000005
0100000000000014 0b10c00000000014
010000000000001c 0b10c0000000001c

//--- icache_top.f
rtl/icache_pkg.sv
rtl/icache_lookup_if.sv
rtl/icache_cachemem.sv
rtl/icache_prefetch.sv
rtl/icache_controller.sv
rtl/icache_top.sv
bench/icache_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f icache_top.f --top-module icache_top_tb \
	-o sim_icache_top \
	&& ./obj_dir/sim_icache_top | tee /dev/stderr | grep "^Test passed$" > /dev/null \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }
